// File: files.f
+incdir+include
src/bus_pkg.sv
src/board_pkg.sv
src/reg_bus_if.sv
src/host_arbiter.sv
src/read_router.sv
src/hub_memory.sv
src/board_regs.sv
src/board_watchdog.sv
src/reg_bus_top.sv
tests/reg_bus_assertions.sv
tests/reg_bus_tb.sv

// File: Makefile
TOOL      := verilator
TOP       := reg_bus_tb
FILELIST  := files.f
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
RUN_FLAGS := +verilator+error+limit+1000
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tests/reg_bus_tb.sv
`include "bus_settings.svh"

module reg_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_SOLO = 40;                 // ops per host, one host at a time
    localparam int N_BOTH = 60;                 // ops per host under contention
    localparam int WD_P   = 3;                  // period for the timeout test
    localparam int N_OPS  = 1 + 64 + 2 * N_SOLO + 2 * N_BOTH + 64 + 40;
    localparam int RUN_CYC = N_OPS * 20 + 3 * WD_P * `WDOG_TICK + 500 + 8 * 160 + 2000;

    logic        sysclk = 1'b0;
    logic        rst;
    logic [3:0]  board_id;
    logic        wdog_clear;
    logic [1:0]  cyc;                           // index is the host number
    logic [1:0]  stb;
    logic [1:0]  we;
    logic [1:0]  ack;
    logic [15:0] adr [2];
    logic [31:0] dat_w [2];
    logic [31:0] dat_r [2];
    logic        wdog_timeout;
    logic [2:0]  wdog_period_status;

    integer      seed0 = 32'he7d0;              // host 0 sequence
    integer      seed1 = 32'he7d0 + 1;          // host 1 sequence, same base seed

    // reference model
    logic [31:0] m_scratch;
    logic [15:0] m_period;
    logic [31:0] m_hub [0:63];
    logic        m_timeout;

    int          errors;                        // wrong values
    int          fails;                         // missing or extra acks
    int          acks_seen [2];
    int          ops_done [2];

    always #5 sysclk = ~sysclk;

    reg_bus_top UUT (
        .sysclk(sysclk), .rst(rst), .board_id(board_id), .wdog_clear(wdog_clear),
        .h0_cyc(cyc[0]), .h0_stb(stb[0]), .h0_we(we[0]), .h0_adr(adr[0]),
        .h0_dat_w(dat_w[0]), .h0_dat_r(dat_r[0]), .h0_ack(ack[0]),
        .h1_cyc(cyc[1]), .h1_stb(stb[1]), .h1_we(we[1]), .h1_adr(adr[1]),
        .h1_dat_w(dat_w[1]), .h1_dat_r(dat_r[1]), .h1_ack(ack[1]),
        .wdog_timeout(wdog_timeout), .wdog_period_status(wdog_period_status)
    );

    bind reg_bus_top reg_bus_assertions chk (
        .sysclk(sysclk), .rst(rst), .h0_cyc(h0_cyc), .h0_stb(h0_stb), .h0_ack(h0_ack),
        .h1_cyc(h1_cyc), .h1_stb(h1_stb), .h1_ack(h1_ack), .wdog_timeout(wdog_timeout)
    );

    // --------------------
    // model rules
    // --------------------
    function automatic logic [31:0] expect_read(input logic [15:0] a);
        logic [31:0] d;
        d = 32'h0;                              // unmapped and bad byte field
        if (a[15:12] == `REGION_HUB)
            d = m_hub[a[5:0]];
        else if (a[15:12] == `REGION_MAIN && a[11:4] == 8'h00)
        begin
            case (a[3:0])
                4'd0:    d = {m_timeout, 3'b000, board_id, 24'h0};
                4'd1:    d = m_scratch;
                4'd2:    d = {16'h0, m_period};
                4'd3:    d = `FW_VERSION;
                default: d = 32'h0;
            endcase
        end
        return d;
    endfunction

    task automatic apply_write(input logic [15:0] a, input logic [31:0] d);
        if (a[15:12] == `REGION_HUB)
            m_hub[a[5:0]] = d;
        else if (a[15:12] == `REGION_MAIN && a[11:4] == 8'h00)
        begin
            if (a[3:0] == 4'd1)
                m_scratch = d;
            if (a[3:0] == 4'd2)
                m_period = d[15:0];
            if (a[3:0] == 4'd0 && d[31])
                m_timeout = 1'b0;               // status write clears the flag
        end
    endtask

    // band of the highest set period bit
    function automatic logic [2:0] period_code(input logic [15:0] p);
        int top;
        top = -1;
        for (int i = 0; i < 16; i++)
            if (p[i])
                top = i;
        if (top < 0)
            return 3'd0;
        if (top < 10)
            return 3'd1;
        return 3'(top - 8);
    endfunction

    // --------------------
    // host driver
    // --------------------
    task automatic bus_op(input int h, input logic w, input logic [15:0] a,
                          input logic [31:0] d);
        logic [31:0] exp_d;
        int          waited;
        @(posedge sysclk);
        #1;
        cyc[h]   = 1'b1;
        stb[h]   = 1'b1;
        we[h]    = w;
        adr[h]   = a;
        dat_w[h] = d;
        waited   = 0;
        @(negedge sysclk);
        while (!ack[h] && waited < 60)
        begin
            waited++;
            @(negedge sysclk);
        end
        if (!ack[h])
        begin
            fails++;
            $display("host %0d got no acknowledge for address %h within 60 cycles", h, a);
        end
        else
        begin
            ops_done[h]++;
            exp_d = expect_read(a);
            if (w)
                apply_write(a, d);              // model follows ack order
            else if (dat_r[h] !== exp_d)
            begin
                errors++;
                $display("ERROR @%0t: host %0d read %h from %h, expected %h",
                         $time, h, dat_r[h], a, exp_d);
            end
        end
        @(posedge sysclk);
        #1;
        cyc[h] = 1'b0;                          // always one idle edge after a cycle
        stb[h] = 1'b0;
        we[h]  = 1'b0;
    endtask

    task automatic random_op(input int h);
        logic [31:0] r;
        logic [31:0] d;
        logic [15:0] a;
        if (h == 0)
        begin
            r = $random(seed0);
            d = $random(seed0);
        end
        else
        begin
            r = $random(seed1);
            d = $random(seed1);
        end
        case (r[2:0])
            3'd0, 3'd1: a = {4'h1, r[26:21], h[0], r[20:16]};  // own half of the hub
            3'd2:       a = 16'h0001;                          // scratch
            3'd3:       a = 16'h0002;                          // watchdog period
            3'd4:       a = 16'h0003;                          // version
            3'd5:       a = {4'h0, r[11:4] | 8'h01, r[15:12]};  // bad byte field
            default:    a = {r[15:13] | 3'b001, r[28:16]};     // unmapped region
        endcase
        bus_op(h, r[3], a, d);
    endtask

    task automatic pulse_clear;
        @(posedge sysclk);
        #1 wdog_clear = 1'b1;
        @(posedge sysclk);
        #1 wdog_clear = 1'b0;
        m_timeout = 1'b0;
    endtask

    task automatic check_timeout(input logic exp, input string what);
        @(negedge sysclk);
        if (wdog_timeout !== exp)
        begin
            errors++;
            $display("ERROR @%0t: wdog_timeout %b %s, expected %b",
                     $time, wdog_timeout, what, exp);
        end
    endtask

    task automatic check_code;
        @(negedge sysclk);
        if (wdog_period_status !== period_code(m_period))
        begin
            errors++;
            $display("ERROR @%0t: period status %0d for period %h, expected %0d",
                     $time, wdog_period_status, m_period, period_code(m_period));
        end
    endtask

    task automatic stay_quiet(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge sysclk);
            if (wdog_timeout)
            begin
                errors++;
                $display("ERROR @%0t: wdog_timeout rose while kept alive", $time);
                break;
            end
        end
    endtask

    always @(negedge sysclk)
    begin
        if (ack[0])
            acks_seen[0]++;
        if (ack[1])
            acks_seen[1]++;
    end

    // --------------------
    // watchdog timer
    // --------------------
    initial
    begin
        repeat (RUN_CYC) @(posedge sysclk);
        $display("run did not finish within %0d cycles, stopped", RUN_CYC);
        $display("CHECKS FAILED");
        $finish;
    end

    // --------------------
    // test sequence
    // --------------------
    initial
    begin
        rst = 1'b1;
        board_id = 4'hb;
        wdog_clear = 1'b0;
        cyc = 2'b00;
        stb = 2'b00;
        we = 2'b00;
        for (int h = 0; h < 2; h++)
        begin
            adr[h] = 16'h0;
            dat_w[h] = 32'h0;
            acks_seen[h] = 0;
            ops_done[h] = 0;
        end
        errors = 0;
        fails = 0;
        m_period = 16'h0;
        m_timeout = 1'b0;
        repeat (10) @(posedge sysclk);
        #1 rst = 1'b0;

        // known contents, hub pattern spans the whole index
        bus_op(0, 1'b1, 16'h0001, 32'h5a5a_0f0f);
        for (int i = 0; i < 64; i++)
            bus_op(1, 1'b1, {4'h1, 6'h0, 6'(i)}, 32'h9e37_0000 + i * 32'h0001_0b01);

        // one host at a time, then both at once
        repeat (N_SOLO) random_op(0);
        repeat (N_SOLO) random_op(1);
        fork
            repeat (N_BOTH) random_op(0);
            repeat (N_BOTH) random_op(1);
        join
        for (int i = 0; i < 64; i++)
            bus_op(i % 2, 1'b0, {4'h1, 6'h0, 6'(i)}, 32'h0);
        bus_op(1, 1'b0, 16'h0001, 32'h0);

        // read-only and unmapped words
        bus_op(0, 1'b1, 16'h0002, 32'h0);       // watchdog off
        pulse_clear();
        bus_op(1, 1'b0, 16'h0000, 32'h0);
        board_id = 4'h6;
        bus_op(0, 1'b0, 16'h0000, 32'h0);
        bus_op(0, 1'b0, 16'h0003, 32'h0);
        bus_op(1, 1'b0, 16'h7001, 32'h0);
        bus_op(0, 1'b0, 16'h0105, 32'h0);
        bus_op(1, 1'b0, 16'h1403, 32'h0);       // hub word with unused bits set

        // period status bands
        for (int i = 0; i < 8; i++)
        begin
            bus_op(0, 1'b1, 16'h0002, 32'($random(seed0) & 16'hffff) >> (i * 2));
            check_code();
        end

        // timeout after exactly WD_P units, kick is the edge after ack
        bus_op(0, 1'b1, 16'h0002, WD_P);
        check_code();
        repeat (WD_P * `WDOG_TICK - 4) @(posedge sysclk);
        check_timeout(1'b0, "3 cycles before the period");
        repeat (6) @(posedge sysclk);
        check_timeout(1'b1, "3 cycles after the period");
        m_timeout = 1'b1;
        bus_op(1, 1'b0, 16'h0000, 32'h0);       // status shows the flag
        pulse_clear();
        check_timeout(1'b0, "after wdog_clear");
        repeat (WD_P * `WDOG_TICK) @(posedge sysclk);
        check_timeout(1'b1, "one period after the status read");
        m_timeout = 1'b1;
        bus_op(0, 1'b1, 16'h0000, 32'h8000_0000);
        check_timeout(1'b0, "after status write with bit 31");
        bus_op(1, 1'b0, 16'h0000, 32'h0);

        // disabled, then kept alive by spaced reads
        bus_op(0, 1'b1, 16'h0002, 32'h0);
        check_code();
        stay_quiet(500);
        bus_op(0, 1'b1, 16'h0002, 32'd4);
        repeat (8)
        begin
            stay_quiet(150);
            bus_op(1, 1'b0, 16'h0001, 32'h0);
        end
        bus_op(0, 1'b1, 16'h0002, 32'h0);

        for (int h = 0; h < 2; h++)
        begin
            if (acks_seen[h] != ops_done[h])
            begin
                fails++;
                $display("host %0d saw %0d acknowledges for %0d completed requests",
                         h, acks_seen[h], ops_done[h]);
            end
        end
        $display("errors: %0d wrong values, %0d handshake failures, %0d assertion failures",
                 errors, fails, UUT.chk.fail_count);
        if (errors == 0 && fails == 0 && UUT.chk.fail_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: tests/reg_bus_assertions.sv
module reg_bus_assertions
(
    input  logic sysclk,
    input  logic rst,
    input  logic h0_cyc,
    input  logic h0_stb,
    input  logic h0_ack,
    input  logic h1_cyc,
    input  logic h1_stb,
    input  logic h1_ack,
    input  logic wdog_timeout
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;             // failed assertions so far

    // --------------------
    // wishbone handshake
    // --------------------
    ack0_in_cycle: assert property (@(posedge sysclk) disable iff (rst)
        h0_ack |-> (h0_cyc && h0_stb))
        else
        begin
            fail_count++;
            $error("host 0 ack outside an open cycle");
        end

    ack1_in_cycle: assert property (@(posedge sysclk) disable iff (rst)
        h1_ack |-> (h1_cyc && h1_stb))
        else
        begin
            fail_count++;
            $error("host 1 ack outside an open cycle");
        end

    // one owner at a time, so never two acks
    single_ack: assert property (@(posedge sysclk) disable iff (rst)
        !(h0_ack && h1_ack))
        else
        begin
            fail_count++;
            $error("both hosts acknowledged together");
        end

    // watchdog comes out of reset quiet
    wdog_quiet_after_reset: assert property (@(posedge sysclk)
        $fell(rst) |-> !wdog_timeout)
        else
        begin
            fail_count++;
            $error("wdog_timeout high right after reset");
        end

endmodule

// File: src/reg_bus_top.sv
`include "bus_settings.svh"

module reg_bus_top
(
    input  logic                sysclk,
    input  logic                rst,
    input  logic [3:0]          board_id,
    input  logic                wdog_clear,

    input  logic                h0_cyc,
    input  logic                h0_stb,
    input  logic                h0_we,
    input  logic [`BUS_AW-1:0]  h0_adr,
    input  logic [`BUS_DW-1:0]  h0_dat_w,
    output logic [`BUS_DW-1:0]  h0_dat_r,
    output logic                h0_ack,

    input  logic                h1_cyc,
    input  logic                h1_stb,
    input  logic                h1_we,
    input  logic [`BUS_AW-1:0]  h1_adr,
    input  logic [`BUS_DW-1:0]  h1_dat_w,
    output logic [`BUS_DW-1:0]  h1_dat_r,
    output logic                h1_ack,

    output logic                wdog_timeout,
    output logic [2:0]          wdog_period_status
);

    logic [`BUS_DW-1:0] reg_rdata;      // board register read data
    logic [`BUS_DW-1:0] mem_rdata;      // hub read data
    logic               mem_sel;        // hub region decode
    logic               wdog_clr;       // clear from STATUS write
    logic [15:0]        wdog_period;    // watchdog period
    logic               kick;           // acked main access

    reg_bus_if bus ();

    // --------------------
    // arbitration and routing
    // --------------------
    host_arbiter arb (
        .sysclk(sysclk), .rst(rst),
        .h0_cyc(h0_cyc), .h0_stb(h0_stb), .h0_we(h0_we), .h0_adr(h0_adr),
        .h0_dat_w(h0_dat_w), .h0_dat_r(h0_dat_r), .h0_ack(h0_ack),
        .h1_cyc(h1_cyc), .h1_stb(h1_stb), .h1_we(h1_we), .h1_adr(h1_adr),
        .h1_dat_w(h1_dat_w), .h1_dat_r(h1_dat_r), .h1_ack(h1_ack),
        .bus(bus)
    );

    read_router router (
        .sysclk(sysclk), .rst(rst), .bus(bus),
        .reg_rdata(reg_rdata), .mem_rdata(mem_rdata), .mem_sel(mem_sel)
    );

    // --------------------
    // targets
    // --------------------
    hub_memory hub (
        .sysclk(sysclk), .bus(bus), .mem_rdata(mem_rdata), .mem_sel(mem_sel)
    );

    board_regs chan0 (
        .sysclk(sysclk), .rst(rst), .bus(bus), .board_id(board_id),
        .wdog_timeout(wdog_timeout), .wdog_clr(wdog_clr),
        .wdog_period(wdog_period), .kick(kick), .reg_rdata(reg_rdata)
    );

    board_watchdog wdog (
        .sysclk(sysclk), .rst(rst), .kick(kick), .wdog_clr(wdog_clr),
        .wdog_clear(wdog_clear), .wdog_period(wdog_period),
        .wdog_timeout(wdog_timeout), .wdog_period_status(wdog_period_status)
    );

endmodule

// File: src/board_watchdog.sv
`include "bus_settings.svh"

module board_watchdog
(
    input  logic                    sysclk,
    input  logic                    rst,
    input  logic                    kick,               // restart the count
    input  logic                    wdog_clr,           // clear from STATUS write
    input  logic                    wdog_clear,         // clear from board pin
    input  logic [15:0]             wdog_period,        // 0 -> disabled
    output logic                    wdog_timeout,
    output board_pkg::wdog_code_t   wdog_period_status
);
    import board_pkg::*;

    localparam int TICK_W = $clog2(`WDOG_TICK);

    logic [TICK_W-1:0] tick_cnt;    // prescaler, sysclk cycles in one unit
    logic [15:0]       unit_cnt;    // whole units since the last kick
    logic              tick_end;    // last cycle of the current unit

    assign tick_end = (tick_cnt == TICK_W'(`WDOG_TICK - 1));

    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            tick_cnt     <= '0;
            unit_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end
        else
        begin
            if (kick || (wdog_period == 16'd0))
            begin
                tick_cnt <= '0;                 // count restarts on kick
                unit_cnt <= '0;
            end
            else if (tick_end)
            begin
                tick_cnt <= '0;
                if (unit_cnt < wdog_period)
                    unit_cnt <= unit_cnt + 16'd1;   // saturates at the period
            end
            else
                tick_cnt <= tick_cnt + 1'b1;

            if (wdog_clr || wdog_clear)
                wdog_timeout <= 1'b0;
            else if (!kick && (wdog_period != 16'd0) && tick_end &&
                     (unit_cnt + 16'd1 == wdog_period))
                wdog_timeout <= 1'b1;           // set and held until cleared
        end
    end

    // period status, band of the highest set bit
    always_comb
    begin
        if (wdog_period == 16'd0)       wdog_period_status = WDOG_CODE_OFF;
        else if (wdog_period[15])       wdog_period_status = WDOG_CODE_MAX;
        else if (wdog_period[14])       wdog_period_status = 3'd6;
        else if (wdog_period[13])       wdog_period_status = 3'd5;
        else if (wdog_period[12])       wdog_period_status = 3'd4;
        else if (wdog_period[11])       wdog_period_status = 3'd3;
        else if (wdog_period[10])       wdog_period_status = 3'd2;
        else                            wdog_period_status = 3'd1;
    end

endmodule

// File: src/board_regs.sv
`include "bus_settings.svh"

module board_regs
(
    input  logic                sysclk,
    input  logic                rst,
    reg_bus_if.target           bus,
    input  logic [3:0]          board_id,       // rotary switch
    input  logic                wdog_timeout,   // flag from the watchdog
    output logic                wdog_clr,       // pulse, STATUS write with bit 31
    output logic [15:0]         wdog_period,    // period in tick units
    output logic                kick,           // acked main access
    output logic [`BUS_DW-1:0]  reg_rdata
);
    import bus_pkg::*;
    import board_pkg::*;

    logic [`BUS_DW-1:0] scratch;    // plain read/write word
    logic               is_main;    // address in the board register region
    logic               byte_ok;    // byte field is zero
    logic               wr;         // write accepted this cycle

    assign is_main = (region_of(bus.addr) == RGN_MAIN);
    assign byte_ok = (bus.addr.regs.zero == 8'h00);
    assign wr      = bus.req & bus.ack & bus.we & is_main & byte_ok;

    // any acked access to the main region restarts the watchdog
    assign kick     = bus.req & bus.ack & is_main;
    assign wdog_clr = wr & (bus.addr.regs.index == REG_STATUS) & bus.wdata[31];

    // --------------------
    // register writes, taken on the ack edge
    // --------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
            wdog_period <= 16'd0;               // watchdog off after reset
        else if (wr && (bus.addr.regs.index == REG_WDOG))
            wdog_period <= bus.wdata[15:0];
    end

    always_ff @(posedge sysclk)
    begin
        if (wr && (bus.addr.regs.index == REG_SCRATCH))
            scratch <= bus.wdata;
    end

    // --------------------
    // read data
    // --------------------
    always_comb
    begin
        reg_rdata = '0;                         // unused index reads zero
        if (byte_ok)
        begin
            case (bus.addr.regs.index)
                REG_STATUS:  reg_rdata = {wdog_timeout, 3'b000, board_id, 24'h0};
                REG_SCRATCH: reg_rdata = scratch;
                REG_WDOG:    reg_rdata = {16'h0, wdog_period};
                REG_VERSION: reg_rdata = `FW_VERSION;
                default:     reg_rdata = '0;
            endcase
        end
    end

endmodule

// File: src/hub_memory.sv
`include "bus_settings.svh"

module hub_memory
(
    input  logic                sysclk,
    reg_bus_if.target           bus,
    output logic [`BUS_DW-1:0]  mem_rdata,  // registered, one cycle after address
    output logic                mem_sel     // address falls in the hub region
);
    import bus_pkg::*;

    localparam int DEPTH = 1 << `HUB_DEPTH_LOG2;

    logic [`BUS_DW-1:0]         mem [0:DEPTH-1];    // hub words
    logic [`HUB_DEPTH_LOG2-1:0] idx;                // word index from mem view

    assign idx     = bus.addr.mem.index;
    assign mem_sel = (region_of(bus.addr) == RGN_HUB);

    // write while the request is up, read every cycle
    always_ff @(posedge sysclk)
    begin
        if (bus.req && bus.we && mem_sel)
            mem[idx] <= bus.wdata;
        mem_rdata <= mem[idx];                      // old data on a same cycle write
    end

endmodule

// File: src/read_router.sv
`include "bus_settings.svh"

module read_router
(
    input  logic                sysclk,
    input  logic                rst,
    reg_bus_if.router           bus,
    input  logic [`BUS_DW-1:0]  reg_rdata,  // board register read data
    input  logic [`BUS_DW-1:0]  mem_rdata,  // hub memory, one cycle late
    input  logic                mem_sel     // hub decode from the memory block
);
    import bus_pkg::*;

    bus_region_e region;        // decoded region of the bus address
    logic        hub_rd;        // read from hub needs one wait state
    logic        hub_wait;      // wait stage for the hub read

    assign region = region_of(bus.addr);
    assign hub_rd = mem_sel & ~bus.we;

    // --------------------
    // read data mux
    // --------------------
    always_comb
    begin
        if (mem_sel)
            bus.rdata = mem_rdata;              // registered in the hub block
        else if (region == RGN_MAIN)
            bus.rdata = reg_rdata;
        else
            bus.rdata = '0;                     // unmapped reads as zero
    end

    // --------------------
    // acknowledge timing
    // --------------------
    // main, unmapped, hub write -> ack 1 cycle after req
    // hub read -> ack 2 cycles after req
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            bus.ack  <= 1'b0;
            hub_wait <= 1'b0;
        end
        else
        begin
            bus.ack  <= 1'b0;                   // ack is a single pulse
            hub_wait <= 1'b0;
            if (bus.req && !bus.ack && !hub_wait)
            begin
                if (hub_rd)
                    hub_wait <= 1'b1;           // let the memory output settle
                else
                    bus.ack  <= 1'b1;
            end
            if (hub_wait)
                bus.ack <= 1'b1;
        end
    end

endmodule

// File: src/host_arbiter.sv
`include "bus_settings.svh"

module host_arbiter
(
    input  logic                sysclk,
    input  logic                rst,

    // host 0, firewire side
    input  logic                h0_cyc,
    input  logic                h0_stb,
    input  logic                h0_we,
    input  logic [`BUS_AW-1:0]  h0_adr,
    input  logic [`BUS_DW-1:0]  h0_dat_w,
    output logic [`BUS_DW-1:0]  h0_dat_r,
    output logic                h0_ack,

    // host 1, ethernet side
    input  logic                h1_cyc,
    input  logic                h1_stb,
    input  logic                h1_we,
    input  logic [`BUS_AW-1:0]  h1_adr,
    input  logic [`BUS_DW-1:0]  h1_dat_w,
    output logic [`BUS_DW-1:0]  h1_dat_r,
    output logic                h1_ack,

    reg_bus_if.initiator        bus
);

    logic grant;                // 0 -> host 0 owns the bus, 1 -> host 1
    logic in_flight;            // request on the bus, waiting for ack
    logic next_grant;           // grant for the next idle edge
    logic granted_stb;          // owner has a request pending

    // --------------------
    // grant selection
    // --------------------
    // host 1 keeps the bus while its cyc is high, else host 0 wins,
    // with no request at all the grant falls back to host 0
    assign next_grant  = h1_cyc & (grant | ~h0_cyc);
    assign granted_stb = grant ? (h1_cyc & h1_stb) : (h0_cyc & h0_stb);

    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            grant     <= 1'b0;          // idle bus rests on host 0
            in_flight <= 1'b0;
        end
        else if (in_flight)
        begin
            if (bus.ack)
                in_flight <= 1'b0;      // ack edge never starts a new request
        end
        else
        begin
            grant <= next_grant;        // only moves while nothing is in flight
            if (granted_stb)
                in_flight <= 1'b1;      // owner seen with stb, issue req
        end
    end

    // --------------------
    // request path
    // --------------------
    assign bus.req   = in_flight;
    assign bus.we    = grant ? h1_we    : h0_we;
    assign bus.addr  = grant ? h1_adr   : h0_adr;
    assign bus.wdata = grant ? h1_dat_w : h0_dat_w;

    // --------------------
    // response path, owner only
    // --------------------
    assign h0_ack   = bus.ack & ~grant;             // other host just waits
    assign h1_ack   = bus.ack &  grant;
    assign h0_dat_r = grant ? '0 : bus.rdata;
    assign h1_dat_r = grant ? bus.rdata : '0;

endmodule

// File: src/reg_bus_if.sv
`include "bus_settings.svh"

interface reg_bus_if;
    import bus_pkg::*;

    logic               req;        // one request in flight, held until ack
    logic               we;         // 1 -> write
    bus_addr_u          addr;       // address, reg or mem view
    logic [`BUS_DW-1:0] wdata;      // write data
    logic [`BUS_DW-1:0] rdata;      // read data, valid with ack
    logic               ack;        // single cycle acknowledge

    // arbiter side
    modport initiator (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    // decode, read mux and wait states
    modport router (
        input  req, we, addr,
        output rdata, ack
    );

    // register block and hub memory
    modport target (
        input  req, we, addr, wdata, ack
    );

endinterface

// File: src/board_pkg.sv
`include "bus_settings.svh"

package board_pkg;

    // --------------------
    // board register indices
    // --------------------
    typedef enum logic [3:0] {
        REG_STATUS  = `REG_STATUS_IDX,          // bit 31 timeout, 27..24 board id
        REG_SCRATCH = `REG_SCRATCH_IDX,         // read/write scratch
        REG_WDOG    = `REG_WDOG_IDX,            // watchdog period, low 16 bits
        REG_VERSION = `REG_VERSION_IDX          // firmware version
    } board_reg_e;

    // watchdog period status code
    //   0     period is zero, watchdog off
    //   1     period below 1024 units
    //   2..7  highest set bit at 10..15
    typedef logic [2:0] wdog_code_t;

    localparam wdog_code_t WDOG_CODE_OFF = 3'd0;    // disabled
    localparam wdog_code_t WDOG_CODE_MAX = 3'd7;    // bit 15 set

endpackage

// File: src/bus_pkg.sv
`include "bus_settings.svh"

package bus_pkg;

    // --------------------
    // address word, decoded two ways
    // --------------------
    typedef struct packed {
        logic [3:0] region;                     // top nibble selects the region
        logic [7:0] zero;                       // must be zero for a valid register
        logic [3:0] index;                      // board register index
    } reg_view_t;

    typedef struct packed {
        logic [3:0]                        region;  // same nibble as reg view
        logic [`BUS_AW-5-`HUB_DEPTH_LOG2:0] unused;  // ignored by the hub
        logic [`HUB_DEPTH_LOG2-1:0]        index;   // hub word index
    } mem_view_t;

    typedef union packed {
        reg_view_t regs;                        // board register access
        mem_view_t mem;                         // hub memory access
    } bus_addr_u;

    typedef enum logic [1:0] {
        RGN_MAIN,
        RGN_HUB,
        RGN_UNMAPPED                            // any other nibble
    } bus_region_e;

    // single decode of the region nibble, shared by every block on the bus
    function automatic bus_region_e region_of(bus_addr_u a);
        case (a.regs.region)
            `REGION_MAIN: return RGN_MAIN;
            `REGION_HUB:  return RGN_HUB;
            default:      return RGN_UNMAPPED;
        endcase
    endfunction

endpackage

// File: include/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// --------------------
// bus widths
// --------------------
`define BUS_AW          16              // address width
`define BUS_DW          32              // data width

// region codes in address bits 15..12
`define REGION_MAIN     4'h0            // board registers
`define REGION_HUB      4'h1            // hub memory

`define HUB_DEPTH_LOG2  6               // 64 hub words

// --------------------
// board register map
// --------------------
`define REG_STATUS_IDX  4'd0            // status, timeout and board id
`define REG_SCRATCH_IDX 4'd1            // free scratch word
`define REG_WDOG_IDX    4'd2            // watchdog period in tick units
`define REG_VERSION_IDX 4'd3            // firmware version, read only

`define FW_VERSION      32'h0007_0100   // version word read back at REG_VERSION
`define WDOG_TICK       64              // sysclk cycles per watchdog unit

`endif
